//--- hdl/mpeg_sys_pkg.sv
package mpeg_sys_pkg;

   localparam int TS_WIDTH       = 33;
   localparam int PACK_HDR_BYTES = 8;   // bytes after the pack start code
   localparam int WINDOW_BYTES   = 5;   // longest field taken from the history

   typedef logic [7:0]          byte_t;
   typedef logic [TS_WIDTH-1:0] ts_t;        // SCR, PTS or DTS in 90 kHz ticks
   typedef logic [21:0]         mux_rate_t;  // units of 50 bytes per second

   // code bytes that follow the 00 00 01 prefix
   localparam byte_t PACK_CODE       = 8'hBA;
   localparam byte_t SYS_HEADER_CODE = 8'hBB;
   localparam byte_t END_CODE        = 8'hB9;
   localparam byte_t PADDING_ID      = 8'hBE;
   localparam byte_t PRIVATE2_ID     = 8'hBF;

   // packet header bytes with a fixed meaning
   localparam byte_t STUFFING_BYTE = 8'hFF;
   localparam byte_t NO_TS_BYTE    = 8'h0F;

   typedef enum logic [2:0] {
      CODE_NONE,
      CODE_PACK,
      CODE_SYS_HEADER,
      CODE_END,
      CODE_PACKET       // any stream id from BC up
   } start_code_t;

   typedef enum logic [3:0] {
      SEQ_HUNT,
      SEQ_PACK_HDR,
      SEQ_LEN,
      SEQ_STUFF,
      SEQ_STD,
      SEQ_TS,
      SEQ_PAYLOAD,
      SEQ_SKIP,
      SEQ_ENDED
   } seq_state_t;

   // five bytes, oldest in [4], carrying 3+8+7+8+7 timestamp bits
   // the oldest byte has the 4-bit prefix on top and a marker in bit 0,
   // the third and fifth bytes end in a marker as well
   function automatic ts_t ts_from_bytes(input byte_t [WINDOW_BYTES-1:0] bytes);
      return {bytes[4][3:1],
              bytes[3],
              bytes[2][7:1],
              bytes[1],
              bytes[0][7:1]};
   endfunction

endpackage

//--- hdl/parse_if.sv
`timescale 1ns/1ps

interface parse_if;

   logic                      code_hit;    // one cycle, after the code byte
   mpeg_sys_pkg::start_code_t code;
   mpeg_sys_pkg::byte_t       code_id;     // raw code byte, the stream id for packets

   // newest byte in [0]
   mpeg_sys_pkg::byte_t [mpeg_sys_pkg::WINDOW_BYTES-1:0] window;
   logic [3:0]                                         byte_index;  // bytes since code

   modport scanner_mp (
      output code_hit,
      output code,
      output code_id
   );

   modport window_mp (
      input  code_hit,
      output window,
      output byte_index
   );

   modport sequencer_mp (
      input code_hit,
      input code,
      input code_id,
      input window,
      input byte_index
   );

endinterface

//--- hdl/bit_deserializer.sv
`timescale 1ns/1ps

module bit_deserializer #(
   parameter bit LSB_FIRST = 1'b1
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                bit_in,
   input  logic                bit_valid,
   output logic                bit_ready,
   output mpeg_sys_pkg::byte_t byte_data,
   output logic                byte_valid,
   input  logic                byte_ready
);

   mpeg_sys_pkg::byte_t shift_q;
   logic [2:0]          bit_cnt;
   logic                full;      // finished byte waiting to be consumed
   logic                bit_take;

   assign bit_ready  = ~full;
   assign bit_take   = bit_valid & bit_ready;
   assign byte_valid = full;
   assign byte_data  = shift_q;   // frozen while full

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         bit_cnt <= 3'd0;
         full    <= 1'b0;
      end
      else
      begin
         if (bit_take)
         begin
            bit_cnt <= bit_cnt + 3'd1;   // wraps on the eighth bit
            if (bit_cnt == 3'd7)
               full <= 1'b1;
         end
         else if (full && byte_ready)
            full <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (bit_take)
      begin
         if (LSB_FIRST)
            shift_q <= {bit_in, shift_q[7:1]};   // first bit ends in bit 0
         else
            shift_q <= {shift_q[6:0], bit_in};
      end
   end

endmodule

//--- hdl/start_code_scanner.sv
`timescale 1ns/1ps

module start_code_scanner (
   input  logic                clk,
   input  logic                rst,
   input  mpeg_sys_pkg::byte_t byte_data,
   input  logic                byte_valid,
   input  logic                byte_ready,
   parse_if.scanner_mp         pif
);

   localparam mpeg_sys_pkg::byte_t FIRST_STREAM_ID = 8'hBC;

   typedef enum logic [1:0] {
      PFX_IDLE,
      PFX_ZERO,
      PFX_ZERO_ZERO,
      PFX_MATCH        // prefix seen, next byte is the code
   } pfx_state_t;

   pfx_state_t                pfx_state;
   mpeg_sys_pkg::start_code_t code_class;
   logic                      take;

   assign take = byte_valid & byte_ready;

   always_comb
   begin
      case (byte_data)
         mpeg_sys_pkg::PACK_CODE:       code_class = mpeg_sys_pkg::CODE_PACK;
         mpeg_sys_pkg::SYS_HEADER_CODE: code_class = mpeg_sys_pkg::CODE_SYS_HEADER;
         mpeg_sys_pkg::END_CODE:        code_class = mpeg_sys_pkg::CODE_END;
         default:
            code_class = (byte_data >= FIRST_STREAM_ID) ? mpeg_sys_pkg::CODE_PACKET
                                                        : mpeg_sys_pkg::CODE_NONE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pfx_state    <= PFX_IDLE;
         pif.code_hit <= 1'b0;
      end
      else
      begin
         pif.code_hit <= 1'b0;
         if (take)
         begin
            case (pfx_state)
               PFX_IDLE:
                  if (byte_data == 8'h00)
                     pfx_state <= PFX_ZERO;
               PFX_ZERO:
                  pfx_state <= (byte_data == 8'h00) ? PFX_ZERO_ZERO : PFX_IDLE;
               PFX_ZERO_ZERO:
                  if (byte_data == 8'h01)
                     pfx_state <= PFX_MATCH;
                  else if (byte_data != 8'h00)   // longer zero runs keep the pair
                     pfx_state <= PFX_IDLE;
               default:
               begin
                  pif.code_hit <= 1'b1;
                  // a zero here may already start the next prefix
                  pfx_state    <= (byte_data == 8'h00) ? PFX_ZERO : PFX_IDLE;
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (take && pfx_state == PFX_MATCH)
      begin
         pif.code    <= code_class;
         pif.code_id <= byte_data;
      end
   end

endmodule

//--- hdl/byte_window.sv
`timescale 1ns/1ps

module byte_window (
   input  logic                clk,
   input  logic                rst,
   input  mpeg_sys_pkg::byte_t byte_data,
   input  logic                byte_valid,
   input  logic                byte_ready,
   parse_if.window_mp          pif
);

   logic take;

   assign take = byte_valid & byte_ready;

   // index N means window[0] holds the Nth byte after the code
   always_ff @(posedge clk)
   begin
      if (rst)
         pif.byte_index <= 4'd0;
      else if (pif.code_hit)
         pif.byte_index <= 4'd0;   // never coincides with a consumed byte
      else if (take && pif.byte_index != 4'hF)
         pif.byte_index <= pif.byte_index + 4'd1;
   end

   always_ff @(posedge clk)
   begin
      if (take)
         pif.window <= {pif.window[mpeg_sys_pkg::WINDOW_BYTES-2:0], byte_data};
   end

endmodule

//--- hdl/stream_sequencer.sv
`timescale 1ns/1ps

module stream_sequencer (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    byte_valid,
   output logic                    byte_ready,
   parse_if.sequencer_mp           pif,
   output logic                    pack_valid,
   output mpeg_sys_pkg::ts_t       scr,
   output mpeg_sys_pkg::mux_rate_t mux_rate,
   output logic                    ts_valid,
   output mpeg_sys_pkg::ts_t       pts,
   output mpeg_sys_pkg::ts_t       dts,
   output logic                    dts_present,
   output mpeg_sys_pkg::byte_t     payload_data,
   output mpeg_sys_pkg::byte_t     payload_id,
   output logic                    payload_last,
   output logic                    payload_valid,
   input  logic                    payload_ready,
   output logic                    stream_end
);

   localparam mpeg_sys_pkg::byte_t FIRST_ES_ID = 8'hC0;   // audio and video ids
   localparam mpeg_sys_pkg::byte_t LAST_ES_ID  = 8'hEF;
   localparam logic [3:0]          SCR_INDEX   = 4'd5;
   localparam logic [3:0]          LEN_INDEX   = 4'd2;
   localparam logic [3:0]          PACK_END    = 4'(mpeg_sys_pkg::PACK_HDR_BYTES);

   mpeg_sys_pkg::seq_state_t state;
   mpeg_sys_pkg::seq_state_t body_next;
   mpeg_sys_pkg::seq_state_t len_next;
   mpeg_sys_pkg::byte_t      cur_id;
   mpeg_sys_pkg::byte_t      cur_byte;
   mpeg_sys_pkg::ts_t        scr_q;
   mpeg_sys_pkg::ts_t        pts_q;
   mpeg_sys_pkg::ts_t        ts_win;
   logic [15:0]              remain;      // packet bytes left, this one included
   logic [15:0]              len_field;
   logic [3:0]               ts_cnt;      // timestamp bytes already seen
   logic                     take;
   logic                     byte_seen;   // window holds a fresh byte
   logic                     last_byte;
   logic                     ts_done;

   assign take       = byte_valid & byte_ready;
   assign byte_ready = ~(payload_valid & ~payload_ready);
   assign cur_byte   = pif.window[0];
   assign len_field  = {pif.window[1], pif.window[0]};
   assign last_byte  = (remain == 16'd1);
   assign ts_win     = mpeg_sys_pkg::ts_from_bytes(pif.window);
   assign ts_done    = (ts_cnt == (dts_present ? 4'd9 : 4'd4));

   // header reports decode straight from the window
   assign pack_valid = byte_seen && state == mpeg_sys_pkg::SEQ_PACK_HDR
                       && pif.byte_index == PACK_END;
   assign ts_valid   = byte_seen && state == mpeg_sys_pkg::SEQ_TS && ts_done;
   assign scr        = scr_q;
   assign mux_rate   = {pif.window[2][6:0], pif.window[1], pif.window[0][7:1]};
   assign pts        = dts_present ? pts_q : ts_win;   // PTS sits 5 bytes back
   assign dts        = ts_win;
   assign payload_data = cur_byte;   // window only moves once the byte is taken

   always_comb
   begin
      if (len_field == 16'd0)
         len_next = mpeg_sys_pkg::SEQ_HUNT;
      else if (cur_id == mpeg_sys_pkg::PRIVATE2_ID)
         len_next = mpeg_sys_pkg::SEQ_PAYLOAD;   // no header fields at all
      else if (cur_id == mpeg_sys_pkg::SYS_HEADER_CODE || cur_id == mpeg_sys_pkg::PADDING_ID)
         len_next = mpeg_sys_pkg::SEQ_SKIP;
      else if (cur_id >= FIRST_ES_ID && cur_id <= LAST_ES_ID)
         len_next = mpeg_sys_pkg::SEQ_STUFF;
      else
         len_next = mpeg_sys_pkg::SEQ_SKIP;      // reserved and private 1
   end

   always_comb
   begin
      body_next = state;
      case (state)
         mpeg_sys_pkg::SEQ_STUFF:
            if (cur_byte == mpeg_sys_pkg::STUFFING_BYTE)
               body_next = mpeg_sys_pkg::SEQ_STUFF;
            else if (cur_byte[7:6] == 2'b01)
               body_next = mpeg_sys_pkg::SEQ_STD;
            else if (cur_byte[7:5] == 3'b001)   // 0010 PTS, 0011 PTS and DTS
               body_next = mpeg_sys_pkg::SEQ_TS;
            else if (cur_byte == mpeg_sys_pkg::NO_TS_BYTE)
               body_next = mpeg_sys_pkg::SEQ_PAYLOAD;
            else
               body_next = mpeg_sys_pkg::SEQ_SKIP;   // broken header, drop the rest
         mpeg_sys_pkg::SEQ_STD:
            body_next = mpeg_sys_pkg::SEQ_STUFF;     // timestamp form comes next
         mpeg_sys_pkg::SEQ_TS:
            if (ts_done)
               body_next = mpeg_sys_pkg::SEQ_PAYLOAD;
         default:
            body_next = state;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state         <= mpeg_sys_pkg::SEQ_HUNT;
         remain        <= 16'd0;
         ts_cnt        <= 4'd0;
         dts_present   <= 1'b0;
         byte_seen     <= 1'b0;
         payload_valid <= 1'b0;
         payload_last  <= 1'b0;
         stream_end    <= 1'b0;
      end
      else
      begin
         byte_seen <= take;

         // payload goes out on the consume edge itself
         if (take && state == mpeg_sys_pkg::SEQ_PAYLOAD)
         begin
            payload_valid <= 1'b1;
            payload_last  <= last_byte;
         end
         else if (payload_ready)
            payload_valid <= 1'b0;

         if (state == mpeg_sys_pkg::SEQ_HUNT)
         begin
            if (pif.code_hit)
            begin
               case (pif.code)
                  mpeg_sys_pkg::CODE_PACK:
                     state <= mpeg_sys_pkg::SEQ_PACK_HDR;
                  mpeg_sys_pkg::CODE_SYS_HEADER, mpeg_sys_pkg::CODE_PACKET:
                     state <= mpeg_sys_pkg::SEQ_LEN;
                  mpeg_sys_pkg::CODE_END:
                  begin
                     stream_end <= 1'b1;   // sticky until reset
                     state      <= mpeg_sys_pkg::SEQ_ENDED;
                  end
                  default:
                     state <= mpeg_sys_pkg::SEQ_HUNT;
               endcase
            end
         end
         else if (byte_seen)
         begin
            case (state)
               mpeg_sys_pkg::SEQ_PACK_HDR:
                  if (pif.byte_index == PACK_END)
                     state <= mpeg_sys_pkg::SEQ_HUNT;
               mpeg_sys_pkg::SEQ_LEN:
                  if (pif.byte_index == LEN_INDEX)
                  begin
                     remain <= len_field;
                     state  <= len_next;
                  end
               mpeg_sys_pkg::SEQ_STUFF, mpeg_sys_pkg::SEQ_STD, mpeg_sys_pkg::SEQ_TS,
               mpeg_sys_pkg::SEQ_SKIP, mpeg_sys_pkg::SEQ_PAYLOAD:
               begin
                  remain <= remain - 16'd1;
                  state  <= last_byte ? mpeg_sys_pkg::SEQ_HUNT : body_next;
                  if (state == mpeg_sys_pkg::SEQ_STUFF && body_next == mpeg_sys_pkg::SEQ_TS)
                  begin
                     ts_cnt      <= 4'd1;
                     dts_present <= cur_byte[4];
                  end
                  else if (state == mpeg_sys_pkg::SEQ_TS)
                     ts_cnt <= ts_cnt + 4'd1;
               end
               default:
                  state <= state;   // ended, bytes are dropped
            endcase
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == mpeg_sys_pkg::SEQ_HUNT && pif.code_hit)
         cur_id <= pif.code_id;
      if (byte_seen && state == mpeg_sys_pkg::SEQ_PACK_HDR && pif.byte_index == SCR_INDEX)
         scr_q <= ts_win;
      if (byte_seen && state == mpeg_sys_pkg::SEQ_TS && dts_present && ts_cnt == 4'd4)
         pts_q <= ts_win;   // held until the DTS completes
      if (take && state == mpeg_sys_pkg::SEQ_PAYLOAD)
         payload_id <= cur_id;
   end

endmodule

//--- hdl/mpeg_sys_demux.sv
`timescale 1ns/1ps

module mpeg_sys_demux #(
   parameter bit LSB_FIRST = 1'b1
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    bit_in,
   input  logic                    bit_valid,
   output logic                    bit_ready,
   output mpeg_sys_pkg::byte_t     payload_data,
   output mpeg_sys_pkg::byte_t     payload_id,
   output logic                    payload_last,
   output logic                    payload_valid,
   input  logic                    payload_ready,
   output logic                    pack_valid,
   output mpeg_sys_pkg::ts_t       scr,
   output mpeg_sys_pkg::mux_rate_t mux_rate,
   output logic                    ts_valid,
   output mpeg_sys_pkg::ts_t       pts,
   output mpeg_sys_pkg::ts_t       dts,
   output logic                    dts_present,
   output logic                    stream_end
);

   mpeg_sys_pkg::byte_t byte_data;
   logic                byte_valid;
   logic                byte_ready;   // from the sequencer only

   parse_if pif ();

   bit_deserializer #(
      .LSB_FIRST (LSB_FIRST)
   ) i_bit_deserializer (
      .clk        (clk),
      .rst        (rst),
      .bit_in     (bit_in),
      .bit_valid  (bit_valid),
      .bit_ready  (bit_ready),
      .byte_data  (byte_data),
      .byte_valid (byte_valid),
      .byte_ready (byte_ready)
   );

   // scanner and window watch the same consumed bytes
   start_code_scanner i_start_code_scanner (
      .clk        (clk),
      .rst        (rst),
      .byte_data  (byte_data),
      .byte_valid (byte_valid),
      .byte_ready (byte_ready),
      .pif        (pif.scanner_mp)
   );

   byte_window i_byte_window (
      .clk        (clk),
      .rst        (rst),
      .byte_data  (byte_data),
      .byte_valid (byte_valid),
      .byte_ready (byte_ready),
      .pif        (pif.window_mp)
   );

   stream_sequencer i_stream_sequencer (
      .clk           (clk),
      .rst           (rst),
      .byte_valid    (byte_valid),
      .byte_ready    (byte_ready),
      .pif           (pif.sequencer_mp),
      .pack_valid    (pack_valid),
      .scr           (scr),
      .mux_rate      (mux_rate),
      .ts_valid      (ts_valid),
      .pts           (pts),
      .dts           (dts),
      .dts_present   (dts_present),
      .payload_data  (payload_data),
      .payload_id    (payload_id),
      .payload_last  (payload_last),
      .payload_valid (payload_valid),
      .payload_ready (payload_ready),
      .stream_end    (stream_end)
   );

endmodule

//--- tb/mpeg_sys_demux_chk.sv
`timescale 1ns/1ps

module mpeg_sys_demux_chk (
   input logic                clk,
   input logic                rst,
   input logic                bit_ready,
   input mpeg_sys_pkg::byte_t payload_data,
   input mpeg_sys_pkg::byte_t payload_id,
   input logic                payload_last,
   input logic                payload_valid,
   input logic                payload_ready,
   input logic                pack_valid,
   input logic                ts_valid,
   input logic                stream_end
);

   // a stalled byte keeps its data, id and last flag
   property payload_held;
      @(posedge clk) disable iff (rst)
         payload_valid && !payload_ready |=>
            payload_valid && $stable(payload_data) && $stable(payload_id)
            && $stable(payload_last);
   endproperty

   property end_sticky;
      @(posedge clk) disable iff (rst)
         stream_end |=> stream_end;
   endproperty

   property pack_single_cycle;
      @(posedge clk) disable iff (rst)
         pack_valid |=> !pack_valid;
   endproperty

   property ts_single_cycle;
      @(posedge clk) disable iff (rst)
         ts_valid |=> !ts_valid;
   endproperty

   property quiet_after_reset;
      @(posedge clk)
         rst |=> bit_ready && !payload_valid && !pack_valid && !ts_valid && !stream_end;
   endproperty

   a_payload_held: assert property (payload_held)
      else $error("payload outputs changed while the byte was stalled");
   a_end_sticky: assert property (end_sticky)
      else $error("stream_end dropped after it was set");
   a_pack_single: assert property (pack_single_cycle)
      else $error("pack_valid stayed high for more than one cycle");
   a_ts_single: assert property (ts_single_cycle)
      else $error("ts_valid stayed high for more than one cycle");
   a_reset_quiet: assert property (quiet_after_reset)
      else $error("outputs not idle in the cycle after reset");

endmodule

bind mpeg_sys_demux mpeg_sys_demux_chk i_mpeg_sys_demux_chk (
   .clk           (clk),
   .rst           (rst),
   .bit_ready     (bit_ready),
   .payload_data  (payload_data),
   .payload_id    (payload_id),
   .payload_last  (payload_last),
   .payload_valid (payload_valid),
   .payload_ready (payload_ready),
   .pack_valid    (pack_valid),
   .ts_valid      (ts_valid),
   .stream_end    (stream_end)
);

//--- tb/tb_mpeg_sys_demux.sv
`timescale 1ns/1ps

module tb_mpeg_sys_demux;

   localparam int CLK_PERIOD = 8;

   logic                    clk;
   logic                    rst;
   logic                    bit_in;
   logic                    bit_valid;
   logic                    bit_ready;
   mpeg_sys_pkg::byte_t     payload_data;
   mpeg_sys_pkg::byte_t     payload_id;
   logic                    payload_last;
   logic                    payload_valid;
   logic                    payload_ready;
   logic                    pack_valid;
   mpeg_sys_pkg::ts_t       scr;
   mpeg_sys_pkg::mux_rate_t mux_rate;
   logic                    ts_valid;
   mpeg_sys_pkg::ts_t       pts;
   mpeg_sys_pkg::ts_t       dts;
   logic                    dts_present;
   logic                    stream_end;

   mpeg_sys_pkg::byte_t     stream_q[$];       // whole stimulus, built before reset
   mpeg_sys_pkg::byte_t     exp_data_q[$];
   mpeg_sys_pkg::byte_t     exp_id_q[$];
   logic                    exp_last_q[$];
   mpeg_sys_pkg::ts_t       exp_scr_q[$];
   mpeg_sys_pkg::mux_rate_t exp_mux_q[$];
   mpeg_sys_pkg::ts_t       exp_pts_q[$];
   mpeg_sys_pkg::ts_t       exp_dts_q[$];
   logic                    exp_has_dts_q[$];

   // per test: name, stall rate, end of its bytes, expected totals so far
   string test_names[$];
   int    test_stall[$];
   int    test_bytes[$];
   int    test_pay[$];
   int    test_pack[$];
   int    test_ts[$];
   bit    test_ends[$];

   logic [31:0] rng;
   bit          recording;
   int          n_pay = 0;
   int          n_pack = 0;
   int          n_ts = 0;
   int          pay_count = 0;
   int          pack_count = 0;
   int          ts_count = 0;
   int          stall_pct = 0;     // percent of cycles with payload_ready low
   int          watchdog_ns = 0;
   int          checks = 0;
   int          errors = 0;

   mpeg_sys_demux #(
      .LSB_FIRST (1'b1)
   ) i_mpeg_sys_demux (
      .clk           (clk),
      .rst           (rst),
      .bit_in        (bit_in),
      .bit_valid     (bit_valid),
      .bit_ready     (bit_ready),
      .payload_data  (payload_data),
      .payload_id    (payload_id),
      .payload_last  (payload_last),
      .payload_valid (payload_valid),
      .payload_ready (payload_ready),
      .pack_valid    (pack_valid),
      .scr           (scr),
      .mux_rate      (mux_rate),
      .ts_valid      (ts_valid),
      .pts           (pts),
      .dts           (dts),
      .dts_present   (dts_present),
      .stream_end    (stream_end)
   );

   function automatic logic [31:0] xorshift32();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic mpeg_sys_pkg::ts_t random_ts();
      logic [31:0] r;
      r = xorshift32();
      return {r[0], xorshift32()};
   endfunction

   function automatic mpeg_sys_pkg::byte_t random_nonzero_byte();
      return 8'(xorshift32() % 255) + 8'd1;   // no 00, so no false prefixes
   endfunction

   task automatic put_byte(input mpeg_sys_pkg::byte_t b);
      stream_q.push_back(b);
   endtask

   task automatic put_code(input mpeg_sys_pkg::byte_t code);
      put_byte(8'h00);
      put_byte(8'h00);
      put_byte(8'h01);
      put_byte(code);
   endtask

   // prefix nibble, then 3, 15 and 15 value bits, each group closed by a marker
   task automatic put_timestamp(input logic [3:0] prefix, input mpeg_sys_pkg::ts_t ts);
      put_byte({prefix, ts[32:30], 1'b1});
      put_byte(ts[29:22]);
      put_byte({ts[21:15], 1'b1});
      put_byte(ts[14:7]);
      put_byte({ts[6:0], 1'b1});
   endtask

   task automatic add_pack();
      mpeg_sys_pkg::ts_t       scr_v;
      mpeg_sys_pkg::mux_rate_t rate;
      logic [31:0]             r;
      scr_v = random_ts();
      r     = xorshift32();
      rate  = r[21:0];
      put_code(mpeg_sys_pkg::PACK_CODE);
      put_timestamp(4'b0010, scr_v);
      put_byte({1'b1, rate[21:15]});
      put_byte(rate[14:7]);
      put_byte({rate[6:0], 1'b1});
      if (recording)
      begin
         exp_scr_q.push_back(scr_v);
         exp_mux_q.push_back(rate);
         n_pack++;
      end
   endtask

   // ts_form 0 is the 0F byte, 1 PTS only, 2 PTS and DTS
   task automatic add_packet(input mpeg_sys_pkg::byte_t id, input int n_stuff,
                             input bit with_std, input int ts_form, input int n_payload);
      int                  hdr_len;
      logic [15:0]         pkt_len;
      logic [31:0]         r;
      mpeg_sys_pkg::ts_t   pts_v;
      mpeg_sys_pkg::ts_t   dts_v;
      mpeg_sys_pkg::byte_t b;
      hdr_len = n_stuff + (with_std ? 2 : 0) + (ts_form == 2 ? 10 : (ts_form == 1 ? 5 : 1));
      if (id == mpeg_sys_pkg::PRIVATE2_ID)
         hdr_len = 0;   // private 2 has no header fields
      pkt_len = 16'(hdr_len + n_payload);
      put_code(id);
      put_byte(pkt_len[15:8]);
      put_byte(pkt_len[7:0]);
      if (id != mpeg_sys_pkg::PRIVATE2_ID)
      begin
         repeat (n_stuff)
            put_byte(mpeg_sys_pkg::STUFFING_BYTE);
         if (with_std)
         begin
            r = xorshift32();
            put_byte({2'b01, r[5:0]});   // scale and buffer size, not reported
            put_byte(r[15:8]);
         end
         pts_v = random_ts();
         dts_v = random_ts();
         case (ts_form)
            2:
            begin
               put_timestamp(4'b0011, pts_v);
               put_timestamp(4'b0001, dts_v);
            end
            1:
               put_timestamp(4'b0010, pts_v);
            default:
               put_byte(mpeg_sys_pkg::NO_TS_BYTE);
         endcase
         if (recording && ts_form != 0)
         begin
            exp_pts_q.push_back(pts_v);
            exp_dts_q.push_back(dts_v);
            exp_has_dts_q.push_back(ts_form == 2);
            n_ts++;
         end
      end
      for (int i = 0; i < n_payload; i++)
      begin
         b = random_nonzero_byte();
         put_byte(b);
         if (recording)
         begin
            exp_data_q.push_back(b);
            exp_id_q.push_back(id);
            exp_last_q.push_back(i == n_payload - 1);
            n_pay++;
         end
      end
   endtask

   task automatic add_skipped_unit(input mpeg_sys_pkg::byte_t id, input int n_body);
      logic [15:0] len;
      len = 16'(n_body);
      put_code(id);
      put_byte(len[15:8]);
      put_byte(len[7:0]);
      repeat (n_body)
         put_byte((id == mpeg_sys_pkg::PADDING_ID) ? 8'hFF : random_nonzero_byte());
   endtask

   task automatic mark_test(input string name, input int stall, input bit ends_stream);
      test_names.push_back(name);
      test_stall.push_back(stall);
      test_bytes.push_back(stream_q.size());
      test_pay.push_back(n_pay);
      test_pack.push_back(n_pack);
      test_ts.push_back(n_ts);
      test_ends.push_back(ends_stream);
   endtask

   task automatic send_byte(input mpeg_sys_pkg::byte_t b);
      for (int i = 0; i < 8; i++)
      begin
         @(negedge clk);
         bit_in    = b[i];   // LSB first
         bit_valid = 1'b1;
         while (!bit_ready)
            @(negedge clk);
      end
   endtask

   task automatic compare_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
      checks++;
      assert (actual === expected)
      else
      begin
         $display("ERROR %s expected %h got %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_payload();
      assert (exp_data_q.size() > 0)
      else
      begin
         $display("payload byte %h of stream %h came out with none expected",
                  payload_data, payload_id);
         errors++;
      end
      if (exp_data_q.size() > 0)
      begin
         compare_value("payload_data", 64'(exp_data_q.pop_front()), 64'(payload_data));
         compare_value("payload_id", 64'(exp_id_q.pop_front()), 64'(payload_id));
         compare_value("payload_last", 64'(exp_last_q.pop_front()), 64'(payload_last));
         pay_count++;
      end
   endtask

   task automatic check_pack_header();
      assert (exp_scr_q.size() > 0)
      else
      begin
         $display("pack header reported with none expected");
         errors++;
      end
      if (exp_scr_q.size() > 0)
      begin
         compare_value("scr", 64'(exp_scr_q.pop_front()), 64'(scr));
         compare_value("mux_rate", 64'(exp_mux_q.pop_front()), 64'(mux_rate));
         pack_count++;
      end
   endtask

   task automatic check_timestamps();
      logic has_dts;
      assert (exp_pts_q.size() > 0)
      else
      begin
         $display("timestamps reported with none expected");
         errors++;
      end
      if (exp_pts_q.size() > 0)
      begin
         has_dts = exp_has_dts_q.pop_front();
         compare_value("pts", 64'(exp_pts_q.pop_front()), 64'(pts));
         compare_value("dts_present", 64'(has_dts), 64'(dts_present));
         if (has_dts)
            compare_value("dts", 64'(exp_dts_q[0]), 64'(dts));
         void'(exp_dts_q.pop_front());
         ts_count++;
      end
   endtask

   initial
   begin
      clk = 1'b0;
      forever
         #(CLK_PERIOD / 2) clk = ~clk;
   end

   // payload_ready and every output are handled on the falling edge
   initial
   begin
      payload_ready = 1'b1;
      forever
      begin
         @(negedge clk);
         if (!rst)
         begin
            if (stall_pct == 0)
               payload_ready = 1'b1;
            else
               payload_ready = (xorshift32() % 100) >= 32'(stall_pct);
            if (payload_valid && payload_ready)
               check_payload();   // taken at the next rising edge
            if (pack_valid)
               check_pack_header();
            if (ts_valid)
               check_timestamps();
         end
      end
   end

   initial
   begin
      wait (watchdog_ns > 0);
      #(watchdog_ns);
      $display("timeout, the stream did not drain within %0d ns", watchdog_ns);
      $display("CHECKS FAILED");
      $finish;
   end

   initial
   begin
      int sent;
      int err_before;
      rst       = 1'b1;
      bit_in    = 1'b0;
      bit_valid = 1'b0;
      rng       = 32'd42;
      recording = 1'b1;

      repeat (3)
         add_pack();
      mark_test("pack header", 0, 1'b0);
      add_pack();
      add_packet(8'hE0, 2, 1'b1, 2, 12);
      mark_test("stuffing, STD and PTS+DTS", 0, 1'b0);
      add_packet(8'hC0, 0, 1'b0, 1, 7);
      add_packet(8'hE1, 1, 1'b0, 0, 5);
      add_packet(mpeg_sys_pkg::PRIVATE2_ID, 0, 1'b0, 0, 6);
      mark_test("PTS only, no timestamp, private 2", 0, 1'b0);
      add_skipped_unit(mpeg_sys_pkg::SYS_HEADER_CODE, 10);
      add_skipped_unit(mpeg_sys_pkg::PADDING_ID, 8);
      add_packet(8'hC3, 0, 1'b0, 1, 4);
      mark_test("system header and padding", 0, 1'b0);
      add_packet(8'hE2, 1, 1'b1, 0, 40);
      mark_test("payload back-pressure", 60, 1'b0);
      put_code(mpeg_sys_pkg::END_CODE);
      recording = 1'b0;   // everything after the end code must stay silent
      add_pack();
      add_packet(8'hC1, 0, 1'b0, 1, 6);
      mark_test("end code", 0, 1'b1);

      watchdog_ns = stream_q.size() * 8 * CLK_PERIOD * 4;

      repeat (3)
         @(posedge clk);
      @(negedge clk);
      rst  = 1'b0;
      sent = 0;

      for (int t = 0; t < test_names.size(); t++)
      begin
         err_before = errors;
         @(posedge clk);
         stall_pct = test_stall[t];
         while (sent < test_bytes[t])
         begin
            send_byte(stream_q[sent]);
            sent++;
         end
         @(negedge clk);
         bit_valid = 1'b0;
         while (pay_count < test_pay[t] || pack_count < test_pack[t] || ts_count < test_ts[t])
            @(posedge clk);
         if (test_ends[t])
         begin
            while (!stream_end)
               @(negedge clk);
            repeat (16)
               @(negedge clk);
            compare_value("stream_end", 64'd1, 64'(stream_end));
         end
         $display("test %0d %s: %s", t + 1, test_names[t],
                  (errors == err_before) ? "ok" : "failed");
      end

      $display("%0d tests, %0d checks, %0d errors", test_names.size(), checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- mpeg_sys_demux.f
hdl/mpeg_sys_pkg.sv
hdl/parse_if.sv
hdl/bit_deserializer.sv
hdl/start_code_scanner.sv
hdl/byte_window.sv
hdl/stream_sequencer.sv
hdl/mpeg_sys_demux.sv
tb/mpeg_sys_demux_chk.sv
tb/tb_mpeg_sys_demux.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the MPEG system demux testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f mpeg_sys_demux.f \
   --top-module tb_mpeg_sys_demux -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
   echo "simulation reported failures"
   exit 1
fi

if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
   echo "simulation ended without a result line"
   exit 1
fi

exit 0
